// File: sim.f
verilog/icache_pkg.sv
verilog/icache_ctrl.sv
verilog/tag_store.sv
verilog/data_store.sv
verilog/plru_victim.sv
verilog/refill_collector.sv
verilog/icache_top.sv
sim/icache_checker.sv
sim/icache_tb.sv

// File: sim/icache_checker.sv
module icache_checker import icache_pkg::*; (
        input  logic        clk,
        input  logic        rst,
        input  logic        req_valid,
        input  logic        req_ready,
        input  fetch_addr_t req_addr,
        input  word_t       exp_data,
        input  logic        exp_miss,
        input  logic        rsp_valid,
        input  logic        rsp_ready,
        input  word_t       rsp_data,
        input  logic        mem_req_valid,
        input  logic        mem_req_ready,
        input  fetch_addr_t mem_req_addr,
        output int          test_count,
        output int          err_count
);

        // expectations of the fetch in flight, pushed at request acceptance
        logic [31:0] addr_q [$];
        word_t       data_q [$];
        logic        miss_q [$];

        logic        miss_seen;
        logic        test_bad;
        logic        rsp_hold;
        word_t       rsp_held;
        logic        mreq_hold;
        fetch_addr_t mreq_held;

        initial begin
                test_count = 0;
                err_count  = 0;
                test_bad   = 1'b0;
        end

        task automatic note_error(input string msg);
                $display("%s", msg);
                err_count++;
                test_bad = 1'b1;
        endtask

        always @(posedge clk) begin
                if (rst) begin
                        miss_seen = 1'b0;
                        rsp_hold  = 1'b0;
                        mreq_hold = 1'b0;
                end else begin
                        // stalled response keeps valid and data
                        if (rsp_hold && (!rsp_valid || rsp_data !== rsp_held))
                                note_error($sformatf("ERR @%0t: stalled response changed, %h was %h",
                                        $time, rsp_data, rsp_held));
                        // stalled memory request keeps valid and address
                        if (mreq_hold && (!mem_req_valid || mem_req_addr !== mreq_held))
                                note_error($sformatf("ERR @%0t: memory request %h dropped or moved",
                                        $time, mreq_held));
                        if (req_valid && req_ready) begin
                                addr_q.push_back(req_addr);
                                data_q.push_back(exp_data);
                                miss_q.push_back(exp_miss);
                                miss_seen = 1'b0;
                        end
                        if (mem_req_valid && mem_req_ready) begin
                                miss_seen = 1'b1;
                                if (addr_q.size() == 0)
                                        note_error("memory request seen with no fetch in flight");
                                else if (mem_req_addr !== {addr_q[0][31:5], 5'b0})
                                        note_error($sformatf("ERR @%0t: memory request %h for fetch %h",
                                                $time, mem_req_addr, addr_q[0]));
                        end
                        if (rsp_valid && rsp_ready) begin
                                if (data_q.size() == 0) begin
                                        note_error("response seen with no fetch in flight");
                                end else begin
                                        if (rsp_data !== data_q[0])
                                                note_error($sformatf("ERR @%0t: fetch %h data %h, expected %h",
                                                        $time, addr_q[0], rsp_data, data_q[0]));
                                        if (miss_seen !== miss_q[0])
                                                note_error($sformatf("ERR @%0t: fetch %h miss %0d, expected %0d",
                                                        $time, addr_q[0], miss_seen, miss_q[0]));
                                        $display("test %0d: fetch %h data %h %s, %s", test_count,
                                                addr_q[0], rsp_data, miss_seen ? "miss" : "hit",
                                                test_bad ? "failed" : "passed");
                                        void'(addr_q.pop_front());
                                        void'(data_q.pop_front());
                                        void'(miss_q.pop_front());
                                end
                                test_count++;
                                test_bad  = 1'b0;
                                miss_seen = 1'b0;
                        end
                        // remember this cycle's stall state for the next edge
                        rsp_hold  = rsp_valid && !rsp_ready;
                        rsp_held  = rsp_data;
                        mreq_hold = mem_req_valid && !mem_req_ready;
                        mreq_held = mem_req_addr;
                end
        end

endmodule

// File: sim/icache_tb.sv
module icache_tb import icache_pkg::*;;

        localparam int TIMEOUT   = 200;
        localparam int MAX_TESTS = 32;

        // one table row: fetch address, expected miss, response stall, slow memory
        typedef struct packed {
                logic [31:0] addr;
                logic        miss;
                logic [3:0]  bp;
                logic        slow;
        } stim_t;

        logic        clk           = 1'b0;
        logic        rst           = 1'b1;
        logic        req_valid     = 1'b0;
        fetch_addr_t req_addr      = '0;
        logic        req_ready;
        logic        rsp_valid;
        word_t       rsp_data;
        logic        rsp_ready     = 1'b0;
        logic        mem_req_valid;
        fetch_addr_t mem_req_addr;
        logic        mem_req_ready = 1'b0;
        logic        mem_rsp_valid = 1'b0;
        mem_beat_t   mem_rsp       = '0;
        logic        mem_rsp_ready;

        word_t       exp_data      = '0;
        logic        exp_miss      = 1'b0;
        int          test_count;
        int          err_count;

        integer      seed          = 32'hc616;
        stim_t       tests [MAX_TESTS];
        int          n_tests       = 0;
        int          cur_bp        = 0;
        logic        mem_slow      = 1'b0;
        int          timeouts      = 0;
        int          tb_errors     = 0;
        logic        stop          = 1'b0;

        // memory model state
        logic        mem_busy      = 1'b0;
        logic [31:0] mem_line      = '0;
        int          mem_beat      = 0;
        int          req_wait      = -1;
        int          valid_cycles  = 0;

        always #5 clk = ~clk;

        icache_top #(.NUM_SETS(8)) i_icache_top (
                .clk           (clk),
                .rst           (rst),
                .req_valid     (req_valid),
                .req_addr      (req_addr),
                .req_ready     (req_ready),
                .rsp_valid     (rsp_valid),
                .rsp_data      (rsp_data),
                .rsp_ready     (rsp_ready),
                .mem_req_valid (mem_req_valid),
                .mem_req_addr  (mem_req_addr),
                .mem_req_ready (mem_req_ready),
                .mem_rsp_valid (mem_rsp_valid),
                .mem_rsp       (mem_rsp),
                .mem_rsp_ready (mem_rsp_ready)
        );

        icache_checker i_checker (
                .clk           (clk),
                .rst           (rst),
                .req_valid     (req_valid),
                .req_ready     (req_ready),
                .req_addr      (req_addr),
                .exp_data      (exp_data),
                .exp_miss      (exp_miss),
                .rsp_valid     (rsp_valid),
                .rsp_ready     (rsp_ready),
                .rsp_data      (rsp_data),
                .mem_req_valid (mem_req_valid),
                .mem_req_ready (mem_req_ready),
                .mem_req_addr  (mem_req_addr),
                .test_count    (test_count),
                .err_count     (err_count)
        );

        // memory contents: word k of a line is line address + 4k, scrambled
        function automatic word_t beat_word(input logic [31:0] line, input int k);
                return (line + 32'(k) * 4) ^ 32'h5a5a_0000;
        endfunction

        task automatic add_test(input logic [31:0] addr, input logic miss,
                                input logic [3:0] bp, input logic slow);
                tests[n_tests] = {addr, miss, bp, slow};
                n_tests++;
        endtask

        // memory side, sampled at the edge and driven just after it
        always @(posedge clk) begin : mem_model
                logic        req_fire;
                logic        beat_fire;
                logic [31:0] req_line;
                req_fire  = mem_req_valid && mem_req_ready;
                beat_fire = mem_rsp_valid && mem_rsp_ready;
                req_line  = mem_req_addr;
                #1;
                if (rst) begin
                        mem_req_ready = 1'b0;
                        mem_rsp_valid = 1'b0;
                        mem_busy      = 1'b0;
                        req_wait      = -1;
                end else begin
                        if (req_fire) begin
                                // burst starts, request side goes quiet
                                mem_req_ready = 1'b0;
                                req_wait      = -1;
                                mem_busy      = 1'b1;
                                mem_line      = req_line;
                                mem_beat      = 0;
                                mem_rsp_valid = 1'b0;
                        end else if (!mem_busy && mem_req_valid && !mem_req_ready) begin
                                // random accept delay, longer for slow tests
                                if (req_wait < 0)
                                        req_wait = ($random(seed) & 3) + (mem_slow ? 4 : 0);
                                if (req_wait == 0)
                                        mem_req_ready = 1'b1;
                                else
                                        req_wait--;
                        end
                        if (beat_fire) begin
                                if (mem_rsp.last) begin
                                        mem_busy      = 1'b0;
                                        mem_rsp_valid = 1'b0;
                                end else begin
                                        mem_beat++;
                                end
                        end
                        // an offered beat stays put, otherwise a new beat or a gap
                        if (mem_busy && (beat_fire || !mem_rsp_valid)) begin
                                if (mem_slow)
                                        mem_rsp_valid = ($random(seed) & 1) != 0;
                                else
                                        mem_rsp_valid = ($random(seed) & 3) != 0;
                                mem_rsp.data = beat_word(mem_line, mem_beat);
                                mem_rsp.last = (mem_beat == WORDS_PER_LINE - 1);
                        end
                end
        end

        // response side: stall cur_bp cycles of valid, then random drops
        always @(posedge clk) begin : rsp_side
                #1;
                if (rst || !rsp_valid)
                        valid_cycles = 0;
                else
                        valid_cycles++;
                if (valid_cycles > cur_bp)
                        rsp_ready = ($random(seed) & 3) != 0;
                else
                        rsp_ready = 1'b0;
        end

        task automatic run_fetch(input stim_t t);
                int   n;
                logic done;
                req_addr  = t.addr;
                exp_data  = beat_word({t.addr[31:5], 5'b0}, int'(t.addr[4:2]));
                exp_miss  = t.miss;
                cur_bp    = t.bp;
                mem_slow  = t.slow;
                req_valid = 1'b1;
                n    = 0;
                done = 1'b0;
                while (!done && n < TIMEOUT) begin
                        @(posedge clk);
                        done = req_ready;
                        n++;
                end
                #1;
                req_valid = 1'b0;
                if (!done) begin
                        $display("timeout: fetch %h was never accepted", t.addr);
                        timeouts++;
                        stop = 1'b1;
                end else begin
                        n    = 0;
                        done = 1'b0;
                        while (!done && n < TIMEOUT) begin
                                @(posedge clk);
                                done = rsp_valid && rsp_ready;
                                n++;
                        end
                        #1;
                        if (!done) begin
                                $display("timeout: no response arrived for fetch %h", t.addr);
                                timeouts++;
                                stop = 1'b1;
                        end
                end
        endtask

        initial begin : stimulus
                int i;
                // cold miss on set 1, then every word of that line and a repeat
                add_test(32'h0000_012c, 1'b1, 4'd0, 1'b0);
                for (i = 0; i < WORDS_PER_LINE; i++)
                        add_test(32'h0000_0120 + 32'(i) * 4, 1'b0, 4'd0, 1'b0);
                add_test(32'h0000_012c, 1'b0, 4'd0, 1'b0);
                // four lines of set 0 fill ways 0 to 3
                add_test(32'h0000_1004, 1'b1, 4'd0, 1'b0);
                add_test(32'h0000_2008, 1'b1, 4'd0, 1'b0);
                add_test(32'h0000_300c, 1'b1, 4'd0, 1'b0);
                add_test(32'h0000_4010, 1'b1, 4'd0, 1'b0);
                // hits to ways 0, 2, 1, 3 leave way 0 as the tree victim
                add_test(32'h0000_101c, 1'b0, 4'd0, 1'b0);
                add_test(32'h0000_3000, 1'b0, 4'd0, 1'b0);
                add_test(32'h0000_2014, 1'b0, 4'd0, 1'b0);
                add_test(32'h0000_4018, 1'b0, 4'd0, 1'b0);
                // fifth line evicts the first one
                add_test(32'h0000_5008, 1'b1, 4'd0, 1'b0);
                add_test(32'h0000_2000, 1'b0, 4'd0, 1'b0);
                add_test(32'h0000_3004, 1'b0, 4'd0, 1'b0);
                add_test(32'h0000_4008, 1'b0, 4'd0, 1'b0);
                add_test(32'h0000_1010, 1'b1, 4'd0, 1'b0);
                // response stalls on a hit and on a miss
                add_test(32'h0000_0130, 1'b0, 4'd6, 1'b0);
                add_test(32'h0000_0644, 1'b1, 4'd9, 1'b0);
                // slow memory with frequent beat gaps
                add_test(32'h0000_0a48, 1'b1, 4'd0, 1'b1);
                add_test(32'h0000_0a5c, 1'b0, 4'd2, 1'b1);

                repeat (16) @(posedge clk);
                #1;
                rst = 1'b0;
                if (!req_ready || rsp_valid || mem_req_valid || mem_rsp_ready) begin
                        $display("ERR @%0t: cache outputs not idle after reset", $time);
                        tb_errors++;
                end
                for (i = 0; i < n_tests && !stop; i++)
                        run_fetch(tests[i]);
                repeat (4) @(posedge clk);
                $display("tests %0d of %0d, check errors %0d, tb errors %0d, timeouts %0d",
                        test_count, n_tests, err_count, tb_errors, timeouts);
                if (err_count == 0 && tb_errors == 0 && timeouts == 0 && test_count == n_tests) begin
                        $display("Everything OK");
                end else begin
                        $display("Something failed");
                end
                $finish;
        end

endmodule

// File: verilog/data_store.sv
module data_store import icache_pkg::*; #(
        parameter int NUM_SETS = 8
) (
        input  logic        clk,
        input  fetch_addr_t cur_addr,
        input  logic        read_en,
        input  way_mask_t   hit_way,
        input  fill_t       fill,
        input  line_t       fill_line,
        output word_t       word
);

        localparam int SET_W = $clog2(NUM_SETS);

        line_t lines [NUM_SETS][NUM_WAYS];

        logic [SET_W-1:0] set_idx;
        logic [SET_W-1:0] fill_set;
        line_t            hit_line;

        assign set_idx  = cur_addr.line_addr[SET_W-1:0];
        assign fill_set = fill.line_addr[SET_W-1:0];

        // hit way is one-hot, so an and-or mux is enough
        always_comb begin
                hit_line = '0;
                for (int w = 0; w < NUM_WAYS; w++) begin
                        if (hit_way[w]) hit_line = hit_line | lines[set_idx][w];
                end
        end

        always_ff @(posedge clk) begin
                if (fill.we) begin
                        for (int w = 0; w < NUM_WAYS; w++) begin
                                if (fill.way[w]) lines[fill_set][w] <= fill_line;
                        end
                        // forward the requested word straight from the refill
                        word <= fill_line[cur_addr.word_idx*WORD_W +: WORD_W];
                end else if (read_en) begin
                        word <= hit_line[cur_addr.word_idx*WORD_W +: WORD_W];
                end
        end

endmodule

// File: verilog/icache_ctrl.sv
module icache_ctrl import icache_pkg::*; (
        input  logic        clk,
        input  logic        rst,
        input  logic        req_valid,
        input  fetch_addr_t req_addr,
        output logic        req_ready,
        output logic        rsp_valid,
        input  logic        rsp_ready,
        output logic        mem_req_valid,
        output fetch_addr_t mem_req_addr,
        input  logic        mem_req_ready,
        output logic        mem_rsp_ready,
        input  logic        hit,
        input  way_mask_t   hit_way,
        input  way_mask_t   victim,
        input  logic        fill_done,
        output fetch_addr_t cur_addr,
        output logic        hit_commit,
        output logic        miss_commit,
        output logic        read_en,
        output fill_t       fill
);

        ctrl_state_e state, state_nxt;
        way_mask_t   victim_q;

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= IDLE;
                end else begin
                        state <= state_nxt;
                end
        end

        always_comb begin
                state_nxt = state;
                case (state)
                        IDLE:    if (req_valid) state_nxt = LOOKUP;
                        LOOKUP:  state_nxt = hit ? READ : MEM_REQ;
                        READ:    state_nxt = RESP;
                        RESP:    if (rsp_ready) state_nxt = IDLE;
                        MEM_REQ: if (mem_req_ready) state_nxt = RECV;
                        // collector flags the burst one cycle after the last beat
                        RECV:    if (fill_done) state_nxt = REFILL;
                        REFILL:  state_nxt = RESP;
                        default: state_nxt = IDLE;
                endcase
        end

        // request address, held for the whole transaction
        always_ff @(posedge clk) begin
                if (rst) begin
                        cur_addr <= '0;
                end else if (req_valid && req_ready) begin
                        cur_addr <= req_addr;
                end
        end

        // way picked at the miss, target of the refill
        always_ff @(posedge clk) begin
                if (state == LOOKUP && !hit) begin
                        victim_q <= victim;
                end
        end

        assign req_ready     = (state == IDLE);
        assign rsp_valid     = (state == RESP);
        assign mem_req_valid = (state == MEM_REQ);
        assign mem_rsp_ready = (state == RECV);
        assign hit_commit    = (state == LOOKUP) && hit;
        // victim valid bit drops here so a half-filled way never hits
        assign miss_commit   = (state == LOOKUP) && !hit;
        assign read_en       = (state == READ);

        // line aligned read address
        always_comb begin
                mem_req_addr           = cur_addr;
                mem_req_addr.word_idx  = '0;
                mem_req_addr.byte_off  = '0;
        end

        always_comb begin
                fill.we        = (state == REFILL);
                fill.way       = victim_q;
                fill.line_addr = cur_addr.line_addr;
        end

        assert property (@(posedge clk) disable iff (rst)
                fill.we |-> $onehot(fill.way));

        // data read in READ relies on the hit way staying put after LOOKUP
        assert property (@(posedge clk) disable iff (rst)
                hit_commit |=> hit && hit_way == $past(hit_way));

endmodule

// File: verilog/icache_pkg.sv
package icache_pkg;

        // basic geometry
        localparam int WORD_W         = 32;
        localparam int WORDS_PER_LINE = 8;
        localparam int NUM_WAYS       = 4;

        // address split: line address, word index, byte offset
        localparam int BYTE_OFF_W  = 2;
        localparam int WORD_IDX_W  = $clog2(WORDS_PER_LINE);
        localparam int LINE_ADDR_W = WORD_W - WORD_IDX_W - BYTE_OFF_W;

        typedef logic [WORD_W-1:0]                line_t_word;
        typedef line_t_word                       word_t;
        typedef logic [WORD_W*WORDS_PER_LINE-1:0] line_t;
        typedef logic [NUM_WAYS-1:0]              way_mask_t;

        // byte address as seen by the fetch port
        typedef struct packed {
                logic [LINE_ADDR_W-1:0] line_addr;
                logic [WORD_IDX_W-1:0]  word_idx;
                logic [BYTE_OFF_W-1:0]  byte_off;  // ignored, fetches are word aligned
        } fetch_addr_t;

        // one beat of the refill burst
        typedef struct packed {
                word_t data;
                logic  last;
        } mem_beat_t;

        // refill write into tags and data
        typedef struct packed {
                logic                   we;
                way_mask_t              way;
                logic [LINE_ADDR_W-1:0] line_addr;
        } fill_t;

        typedef enum logic [2:0] {
                IDLE,
                LOOKUP,
                READ,
                RESP,
                MEM_REQ,
                RECV,
                REFILL
        } ctrl_state_e;

endpackage

// File: verilog/icache_top.sv
module icache_top import icache_pkg::*; #(
        parameter int NUM_SETS = 8
) (
        input  logic        clk,
        input  logic        rst,
        // cpu fetch
        input  logic        req_valid,
        input  fetch_addr_t req_addr,
        output logic        req_ready,
        output logic        rsp_valid,
        output word_t       rsp_data,
        input  logic        rsp_ready,
        // memory read
        output logic        mem_req_valid,
        output fetch_addr_t mem_req_addr,
        input  logic        mem_req_ready,
        input  logic        mem_rsp_valid,
        input  mem_beat_t   mem_rsp,
        output logic        mem_rsp_ready
);

        fetch_addr_t cur_addr;
        logic        hit;
        way_mask_t   hit_way;
        way_mask_t   valid_bits;
        way_mask_t   victim;
        logic        hit_commit;
        logic        miss_commit;
        logic        read_en;
        fill_t       fill;
        line_t       fill_line;
        logic        fill_done;

        icache_ctrl i_ctrl (
                .clk           (clk),
                .rst           (rst),
                .req_valid     (req_valid),
                .req_addr      (req_addr),
                .req_ready     (req_ready),
                .rsp_valid     (rsp_valid),
                .rsp_ready     (rsp_ready),
                .mem_req_valid (mem_req_valid),
                .mem_req_addr  (mem_req_addr),
                .mem_req_ready (mem_req_ready),
                .mem_rsp_ready (mem_rsp_ready),
                .hit           (hit),
                .hit_way       (hit_way),
                .victim        (victim),
                .fill_done     (fill_done),
                .cur_addr      (cur_addr),
                .hit_commit    (hit_commit),
                .miss_commit   (miss_commit),
                .read_en       (read_en),
                .fill          (fill)
        );

        tag_store #(.NUM_SETS(NUM_SETS)) i_tag_store (
                .clk         (clk),
                .rst         (rst),
                .cur_addr    (cur_addr),
                .miss_commit (miss_commit),
                .victim      (victim),
                .fill        (fill),
                .hit         (hit),
                .hit_way     (hit_way),
                .valid_bits  (valid_bits)
        );

        // registered word doubles as the response data
        data_store #(.NUM_SETS(NUM_SETS)) i_data_store (
                .clk       (clk),
                .cur_addr  (cur_addr),
                .read_en   (read_en),
                .hit_way   (hit_way),
                .fill      (fill),
                .fill_line (fill_line),
                .word      (rsp_data)
        );

        plru_victim #(.NUM_SETS(NUM_SETS)) i_plru_victim (
                .clk        (clk),
                .rst        (rst),
                .cur_addr   (cur_addr),
                .hit_commit (hit_commit),
                .hit_way    (hit_way),
                .valid_bits (valid_bits),
                .victim     (victim)
        );

        refill_collector i_refill_collector (
                .clk           (clk),
                .rst           (rst),
                .mem_rsp_valid (mem_rsp_valid),
                .mem_rsp       (mem_rsp),
                .mem_rsp_ready (mem_rsp_ready),
                .line          (fill_line),
                .fill_done     (fill_done)
        );

endmodule

// File: verilog/plru_victim.sv
module plru_victim import icache_pkg::*; #(
        parameter int NUM_SETS = 8
) (
        input  logic        clk,
        input  logic        rst,
        input  fetch_addr_t cur_addr,
        input  logic        hit_commit,
        input  way_mask_t   hit_way,
        input  way_mask_t   valid_bits,
        output way_mask_t   victim
);

        localparam int SET_W = $clog2(NUM_SETS);

        // root: upper pair used last, lo: way 1 used last, hi: way 3 used last
        logic [NUM_SETS-1:0] age_root;
        logic [NUM_SETS-1:0] age_lo;
        logic [NUM_SETS-1:0] age_hi;

        logic [SET_W-1:0] set_idx;
        way_mask_t        inv;
        way_mask_t        first_inv;
        way_mask_t        tree_way;

        assign set_idx = cur_addr.line_addr[SET_W-1:0];

        always_ff @(posedge clk) begin
                if (rst) begin
                        age_root <= '0;
                        age_lo   <= '0;
                        age_hi   <= '0;
                end else if (hit_commit) begin
                        age_root[set_idx] <= hit_way[2] | hit_way[3];
                        // only the pair that was hit moves its own bit
                        if (hit_way[0] | hit_way[1]) age_lo[set_idx] <= hit_way[1];
                        if (hit_way[2] | hit_way[3]) age_hi[set_idx] <= hit_way[3];
                end
        end

        // lowest numbered invalid way
        assign inv       = ~valid_bits;
        assign first_inv = inv & (~inv + way_mask_t'(1));

        // walk the tree away from the recently used side
        always_comb begin
                tree_way = '0;
                if (age_root[set_idx]) begin
                        tree_way[age_lo[set_idx] ? 0 : 1] = 1'b1;
                end else begin
                        tree_way[age_hi[set_idx] ? 2 : 3] = 1'b1;
                end
        end

        assign victim = (|inv) ? first_inv : tree_way;

        assert property (@(posedge clk) disable iff (rst) $onehot(victim));

endmodule

// File: verilog/refill_collector.sv
module refill_collector import icache_pkg::*; (
        input  logic      clk,
        input  logic      rst,
        input  logic      mem_rsp_valid,
        input  mem_beat_t mem_rsp,
        input  logic      mem_rsp_ready,
        output line_t     line,
        output logic      fill_done
);

        logic [WORD_IDX_W-1:0] beat_cnt;
        logic                  beat_acc;

        assign beat_acc = mem_rsp_valid && mem_rsp_ready;

        // beats come in word order, slot follows the counter
        always_ff @(posedge clk) begin
                if (beat_acc) begin
                        line[beat_cnt*WORD_W +: WORD_W] <= mem_rsp.data;
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        beat_cnt  <= '0;
                        fill_done <= 1'b0;
                end else begin
                        fill_done <= beat_acc && mem_rsp.last;
                        if (beat_acc) begin
                                // wrap on last, ready for the next burst
                                beat_cnt <= mem_rsp.last ? '0 : beat_cnt + 1'b1;
                        end
                end
        end

        // burst length must match the line
        assert property (@(posedge clk) disable iff (rst)
                beat_acc |-> (mem_rsp.last == (beat_cnt == WORD_IDX_W'(WORDS_PER_LINE - 1))));

endmodule

// File: verilog/tag_store.sv
module tag_store import icache_pkg::*; #(
        parameter int NUM_SETS = 8
) (
        input  logic        clk,
        input  logic        rst,
        input  fetch_addr_t cur_addr,
        input  logic        miss_commit,
        input  way_mask_t   victim,
        input  fill_t       fill,
        output logic        hit,
        output way_mask_t   hit_way,
        output way_mask_t   valid_bits
);

        localparam int SET_W = $clog2(NUM_SETS);
        localparam int TAG_W = LINE_ADDR_W - SET_W;

        logic [TAG_W-1:0] tags [NUM_SETS][NUM_WAYS];
        way_mask_t        valid [NUM_SETS];

        logic [SET_W-1:0] set_idx;
        logic [TAG_W-1:0] tag_req;
        logic [SET_W-1:0] fill_set;
        logic [TAG_W-1:0] fill_tag;

        // set index is the low part of the line address
        assign set_idx  = cur_addr.line_addr[SET_W-1:0];
        assign tag_req  = cur_addr.line_addr[LINE_ADDR_W-1:SET_W];
        assign fill_set = fill.line_addr[SET_W-1:0];
        assign fill_tag = fill.line_addr[LINE_ADDR_W-1:SET_W];

        // compare against every way of the set
        always_comb begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                        hit_way[w] = valid[set_idx][w] && (tags[set_idx][w] == tag_req);
                end
        end

        assign hit        = |hit_way;
        assign valid_bits = valid[set_idx];

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int s = 0; s < NUM_SETS; s++) begin
                                valid[s] <= '0;
                        end
                end else if (miss_commit) begin
                        // evict up front
                        valid[set_idx] <= valid[set_idx] & ~victim;
                end else if (fill.we) begin
                        valid[fill_set] <= valid[fill_set] | fill.way;
                end
        end

        // tags carry no reset, valid bits guard them
        always_ff @(posedge clk) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                        if (fill.we && fill.way[w]) begin
                                tags[fill_set][w] <= fill_tag;
                        end
                end
        end

        assert property (@(posedge clk) disable iff (rst) $onehot0(hit_way));

endmodule
